// File: common/hpdcache_pkg.sv
// Cache geometry, address field helpers and request/response types
package hpdcache_pkg;

    localparam int NREQUESTERS    = 2;
    localparam int RSP_SOURCES    = 2;
    localparam int ADDR_WIDTH     = 16;
    localparam int WORD_WIDTH     = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_WIDTH     = WORD_WIDTH * WORDS_PER_LINE;
    localparam int SETS           = 16;
    localparam int OFFSET_WIDTH   = $clog2(LINE_WIDTH / 8);
    localparam int SET_WIDTH      = $clog2(SETS);
    localparam int NLINE_WIDTH    = ADDR_WIDTH - OFFSET_WIDTH;
    localparam int TAG_WIDTH      = NLINE_WIDTH - SET_WIDTH;
    localparam int WORD_IDX_WIDTH = $clog2(WORDS_PER_LINE);
    localparam int SID_WIDTH      = 1;
    localparam int TID_WIDTH      = 4;

    typedef logic [ADDR_WIDTH-1:0]     hpdcache_addr_t;
    typedef logic [NLINE_WIDTH-1:0]    hpdcache_nline_t;
    typedef logic [TAG_WIDTH-1:0]      hpdcache_tag_t;
    typedef logic [SET_WIDTH-1:0]      hpdcache_set_t;
    typedef logic [WORD_IDX_WIDTH-1:0] hpdcache_word_t;
    typedef logic [WORD_WIDTH-1:0]     hpdcache_data_t;
    typedef logic [LINE_WIDTH-1:0]     hpdcache_line_t;
    typedef logic [SID_WIDTH-1:0]      hpdcache_sid_t;
    typedef logic [TID_WIDTH-1:0]      hpdcache_tid_t;

    typedef struct packed {
        hpdcache_addr_t addr;
        hpdcache_sid_t  sid;
        hpdcache_tid_t  tid;
    } hpdcache_req_t;

    typedef struct packed {
        hpdcache_data_t data;
        hpdcache_sid_t  sid;
        hpdcache_tid_t  tid;
    } hpdcache_rsp_t;

    function automatic hpdcache_nline_t get_nline(hpdcache_addr_t addr);
        return addr[ADDR_WIDTH-1:OFFSET_WIDTH];
    endfunction

    // Word index sits just below the line number
    function automatic hpdcache_word_t get_word(hpdcache_addr_t addr);
        return addr[OFFSET_WIDTH-1 -: WORD_IDX_WIDTH];
    endfunction

    function automatic hpdcache_set_t get_set(hpdcache_nline_t nline);
        return nline[SET_WIDTH-1:0];
    endfunction

    function automatic hpdcache_tag_t get_tag(hpdcache_nline_t nline);
        return nline[NLINE_WIDTH-1:SET_WIDTH];
    endfunction

    function automatic hpdcache_data_t select_word(hpdcache_line_t line, hpdcache_word_t word);
        return line[int'(word) * WORD_WIDTH +: WORD_WIDTH];
    endfunction

endpackage

// File: common/hpdcache_refill_if.sv
// Miss request path from lookup to miss handler, with refill write and completion back
`timescale 1ns/10ps
interface hpdcache_refill_if;

    // Miss request
    logic                          miss_valid;
    logic                          miss_ready;
    hpdcache_pkg::hpdcache_req_t   miss_req;
    logic                          miss_alloc;

    // One-cycle array write
    logic                          refill_write;
    hpdcache_pkg::hpdcache_nline_t refill_nline;
    hpdcache_pkg::hpdcache_line_t  refill_line;

    // Miss response handed over
    logic                          miss_done;

    modport lookup (
        output miss_valid, miss_req, miss_alloc,
        input  miss_ready, refill_write, refill_nline, refill_line, miss_done
    );

    modport miss_handler (
        input  miss_valid, miss_req, miss_alloc,
        output miss_ready, refill_write, refill_nline, refill_line, miss_done
    );

endinterface

// File: design/hpdcache_fxarb.sv
// Fixed-priority arbiter with grant lock and payload multiplexer
`timescale 1ns/10ps
module hpdcache_fxarb #(
    parameter int  N         = 2,
    parameter type payload_t = logic
) (
    input  logic         clk_i,
    input  logic         rst_n_i,
    input  logic [N-1:0] req_valid_i,
    input  payload_t     payload_i [N],
    input  logic         ready_i,
    output logic [N-1:0] req_ready_o,
    output logic         valid_o,
    output payload_t     payload_o,
    output logic [N-1:0] gnt_o
);

    logic [N-1:0] gnt_prio;
    logic [N-1:0] gnt_q;
    logic         lock_q;

    // Lowest index wins
    always_comb begin
        gnt_prio = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (req_valid_i[i]) begin
                gnt_prio    = '0;
                gnt_prio[i] = 1'b1;
            end
        end
    end

    // Grant held while the output is stalled so the payload stays put
    assign gnt_o       = lock_q ? gnt_q : gnt_prio;
    assign valid_o     = |(gnt_o & req_valid_i);
    assign req_ready_o = gnt_o & {N{ready_i}};

    always_comb begin
        payload_o = payload_i[0];
        for (int i = 1; i < N; i++) begin
            if (gnt_o[i]) begin
                payload_o = payload_i[i];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            lock_q <= 1'b0;
            gnt_q  <= '0;
        end else begin
            lock_q <= valid_o & ~ready_i;
            gnt_q  <= gnt_o;
        end
    end

    payload_stable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o && !ready_i |=> valid_o && $stable(payload_o));

endmodule

// File: lookup/hpdcache_lookup.sv
// Lookup stage with request register, direct-mapped arrays and hit response register
`timescale 1ns/10ps
module hpdcache_lookup (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        req_valid_i,
    input  hpdcache_pkg::hpdcache_req_t req_i,
    input  logic                        cfg_enable_i,
    input  logic                        rsp_ready_i,
    output logic                        req_ready_o,
    output logic                        rsp_valid_o,
    output hpdcache_pkg::hpdcache_rsp_t rsp_o,
    output logic                        evt_read_req_o,
    output logic                        evt_read_miss_o,
    hpdcache_refill_if.lookup           refill
);

    hpdcache_pkg::hpdcache_tag_t   tag_q  [hpdcache_pkg::SETS];
    hpdcache_pkg::hpdcache_line_t  data_q [hpdcache_pkg::SETS];
    logic [hpdcache_pkg::SETS-1:0] valid_q;

    logic                          st1_valid_q;
    logic                          st1_enable_q;
    hpdcache_pkg::hpdcache_req_t   st1_req_q;
    hpdcache_pkg::hpdcache_nline_t st1_nline;
    hpdcache_pkg::hpdcache_set_t   st1_set;
    hpdcache_pkg::hpdcache_set_t   refill_set;
    logic                          hit;
    logic                          st1_to_st2;
    logic                          req_accept;
    logic                          miss_xfer;
    logic                          miss_pending_q;

    assign st1_nline  = hpdcache_pkg::get_nline(st1_req_q.addr);
    assign st1_set    = hpdcache_pkg::get_set(st1_nline);
    assign refill_set = hpdcache_pkg::get_set(refill.refill_nline);

    // Caching off forces a miss
    assign hit = st1_valid_q & st1_enable_q & valid_q[st1_set]
               & (tag_q[st1_set] == hpdcache_pkg::get_tag(st1_nline));

    // Hit moves on when the response slot is free or being emptied
    assign st1_to_st2  = hit & (~rsp_valid_o | rsp_ready_i);
    assign miss_xfer   = refill.miss_valid & refill.miss_ready;
    assign req_ready_o = ~miss_pending_q & (~st1_valid_q | st1_to_st2);
    assign req_accept  = req_valid_i & req_ready_o;

    assign refill.miss_valid = st1_valid_q & ~hit;
    assign refill.miss_req   = st1_req_q;
    assign refill.miss_alloc = st1_enable_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            st1_valid_q     <= 1'b0;
            rsp_valid_o     <= 1'b0;
            miss_pending_q  <= 1'b0;
            valid_q         <= '0;
            evt_read_req_o  <= 1'b0;
            evt_read_miss_o <= 1'b0;
        end else begin
            if (req_accept) begin
                st1_valid_q <= 1'b1;
            end else if (st1_to_st2 || miss_xfer) begin
                st1_valid_q <= 1'b0;
            end

            if (st1_to_st2) begin
                rsp_valid_o <= 1'b1;
            end else if (rsp_ready_i) begin
                rsp_valid_o <= 1'b0;
            end

            // Blocked from the miss transfer until the miss response leaves
            if (miss_xfer) begin
                miss_pending_q <= 1'b1;
            end else if (refill.miss_done) begin
                miss_pending_q <= 1'b0;
            end

            if (refill.refill_write) begin
                valid_q[refill_set] <= 1'b1;
            end

            evt_read_req_o  <= req_accept;
            evt_read_miss_o <= miss_xfer;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_accept) begin
            st1_req_q    <= req_i;
            st1_enable_q <= cfg_enable_i;
        end
        if (st1_to_st2) begin
            rsp_o.data <= hpdcache_pkg::select_word(data_q[st1_set],
                                                    hpdcache_pkg::get_word(st1_req_q.addr));
            rsp_o.sid  <= st1_req_q.sid;
            rsp_o.tid  <= st1_req_q.tid;
        end
        if (refill.refill_write) begin
            tag_q[refill_set]  <= hpdcache_pkg::get_tag(refill.refill_nline);
            data_q[refill_set] <= refill.refill_line;
        end
    end

    no_accept_on_miss_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !refill.miss_ready |-> !req_accept);

    refill_in_miss_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        refill.refill_write |-> miss_pending_q && !st1_valid_q);

endmodule

// File: miss_handler/hpdcache_miss_handler.sv
// Blocking miss handler with one line fetch, refill strobe and miss response
`timescale 1ns/10ps
module hpdcache_miss_handler (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          mem_req_ready_i,
    input  logic                          mem_rsp_valid_i,
    input  hpdcache_pkg::hpdcache_line_t  mem_rsp_data_i,
    input  logic                          rsp_ready_i,
    output logic                          mem_req_valid_o,
    output hpdcache_pkg::hpdcache_nline_t mem_req_nline_o,
    output logic                          rsp_valid_o,
    output hpdcache_pkg::hpdcache_rsp_t   rsp_o,
    hpdcache_refill_if.miss_handler       refill
);

    typedef enum logic [1:0] {
        MISS_IDLE,
        MISS_MEM_REQ,
        MISS_WAIT_LINE,
        MISS_RESPOND
    } miss_state_e;

    miss_state_e                  state_q;
    hpdcache_pkg::hpdcache_req_t  req_q;
    logic                         alloc_q;
    hpdcache_pkg::hpdcache_line_t line_q;
    logic                         refill_write_q;

    assign refill.miss_ready = (state_q == MISS_IDLE);
    assign mem_req_valid_o   = (state_q == MISS_MEM_REQ);
    assign mem_req_nline_o   = hpdcache_pkg::get_nline(req_q.addr);
    assign rsp_valid_o       = (state_q == MISS_RESPOND);

    // Requested word picked out of the fetched line
    assign rsp_o = '{
        data: hpdcache_pkg::select_word(line_q, hpdcache_pkg::get_word(req_q.addr)),
        sid:  req_q.sid,
        tid:  req_q.tid
    };

    assign refill.refill_write = refill_write_q;
    assign refill.refill_nline = mem_req_nline_o;
    assign refill.refill_line  = line_q;
    assign refill.miss_done    = rsp_valid_o & rsp_ready_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q        <= MISS_IDLE;
            refill_write_q <= 1'b0;
        end else begin
            refill_write_q <= 1'b0;
            case (state_q)
                MISS_IDLE: begin
                    if (refill.miss_valid) begin
                        state_q <= MISS_MEM_REQ;
                    end
                end
                MISS_MEM_REQ: begin
                    if (mem_req_ready_i) begin
                        state_q <= MISS_WAIT_LINE;
                    end
                end
                MISS_WAIT_LINE: begin
                    if (mem_rsp_valid_i) begin
                        state_q        <= MISS_RESPOND;
                        refill_write_q <= alloc_q;
                    end
                end
                MISS_RESPOND: begin
                    if (rsp_ready_i) begin
                        state_q <= MISS_IDLE;
                    end
                end
                default: state_q <= MISS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (refill.miss_valid && refill.miss_ready) begin
            req_q   <= refill.miss_req;
            alloc_q <= refill.miss_alloc;
        end
        if (state_q == MISS_WAIT_LINE && mem_rsp_valid_i) begin
            line_q <= mem_rsp_data_i;
        end
    end

    // Memory must only answer an accepted line fetch
    mem_rsp_in_wait_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_rsp_valid_i |-> state_q == MISS_WAIT_LINE);

endmodule

// File: design/hpdcache.sv
// Read-only data cache top with request arbitration, lookup, miss handling, response routing
`timescale 1ns/10ps
module hpdcache (
    input  logic                                                           clk_i,
    input  logic                                                           rst_n_i,
    input  logic [hpdcache_pkg::NREQUESTERS-1:0]                           core_req_valid_i,
    output logic [hpdcache_pkg::NREQUESTERS-1:0]                           core_req_ready_o,
    input  logic [hpdcache_pkg::NREQUESTERS-1:0][hpdcache_pkg::ADDR_WIDTH-1:0] core_req_addr_i,
    input  logic [hpdcache_pkg::NREQUESTERS-1:0][hpdcache_pkg::TID_WIDTH-1:0]  core_req_tid_i,
    output logic [hpdcache_pkg::NREQUESTERS-1:0]                           core_rsp_valid_o,
    input  logic [hpdcache_pkg::NREQUESTERS-1:0]                           core_rsp_ready_i,
    output logic [hpdcache_pkg::WORD_WIDTH-1:0]                            core_rsp_data_o,
    output logic [hpdcache_pkg::TID_WIDTH-1:0]                             core_rsp_tid_o,
    input  logic                                                           mem_req_ready_i,
    output logic                                                           mem_req_valid_o,
    output logic [hpdcache_pkg::NLINE_WIDTH-1:0]                           mem_req_nline_o,
    input  logic                                                           mem_rsp_valid_i,
    input  logic [hpdcache_pkg::LINE_WIDTH-1:0]                            mem_rsp_data_i,
    input  logic                                                           cfg_enable_i,
    output logic                                                           evt_read_req_o,
    output logic                                                           evt_read_miss_o
);

    hpdcache_pkg::hpdcache_req_t             core_req [hpdcache_pkg::NREQUESTERS];
    logic [hpdcache_pkg::NREQUESTERS-1:0]    req_gnt;
    logic                                    arb_req_valid;
    logic                                    arb_req_ready;
    hpdcache_pkg::hpdcache_req_t             arb_req_raw;
    hpdcache_pkg::hpdcache_req_t             arb_req;
    hpdcache_pkg::hpdcache_sid_t             arb_sid;

    logic                                    lookup_rsp_valid;
    hpdcache_pkg::hpdcache_rsp_t             lookup_rsp;
    logic                                    miss_rsp_valid;
    hpdcache_pkg::hpdcache_rsp_t             miss_rsp;
    hpdcache_pkg::hpdcache_rsp_t             rsp_in [hpdcache_pkg::RSP_SOURCES];
    logic [hpdcache_pkg::RSP_SOURCES-1:0]    rsp_in_ready;
    logic                                    rsp_valid;
    logic                                    rsp_ready;
    hpdcache_pkg::hpdcache_rsp_t             rsp;

    hpdcache_refill_if refill_if ();

    for (genvar gen_i = 0; gen_i < hpdcache_pkg::NREQUESTERS; gen_i++) begin : gen_core_req
        assign core_req[gen_i] = '{
            addr: core_req_addr_i[gen_i],
            sid:  '0,
            tid:  core_req_tid_i[gen_i]
        };
    end

    hpdcache_fxarb #(
        .N          (hpdcache_pkg::NREQUESTERS),
        .payload_t  (hpdcache_pkg::hpdcache_req_t)
    ) req_arbiter_i (
        .clk_i,
        .rst_n_i,
        .req_valid_i (core_req_valid_i),
        .payload_i   (core_req),
        .ready_i     (arb_req_ready),
        .req_ready_o (core_req_ready_o),
        .valid_o     (arb_req_valid),
        .payload_o   (arb_req_raw),
        .gnt_o       (req_gnt)
    );

    // Source id is the index of the granted requester
    always_comb begin
        arb_sid = '0;
        for (int i = 0; i < hpdcache_pkg::NREQUESTERS; i++) begin
            if (req_gnt[i]) begin
                arb_sid = hpdcache_pkg::hpdcache_sid_t'(i);
            end
        end
    end

    assign arb_req = '{addr: arb_req_raw.addr, sid: arb_sid, tid: arb_req_raw.tid};

    hpdcache_lookup lookup_i (
        .clk_i,
        .rst_n_i,
        .req_valid_i     (arb_req_valid),
        .req_i           (arb_req),
        .cfg_enable_i,
        .rsp_ready_i     (rsp_in_ready[1]),
        .req_ready_o     (arb_req_ready),
        .rsp_valid_o     (lookup_rsp_valid),
        .rsp_o           (lookup_rsp),
        .evt_read_req_o,
        .evt_read_miss_o,
        .refill          (refill_if)
    );

    hpdcache_miss_handler miss_handler_i (
        .clk_i,
        .rst_n_i,
        .mem_req_ready_i,
        .mem_rsp_valid_i,
        .mem_rsp_data_i,
        .rsp_ready_i     (rsp_in_ready[0]),
        .mem_req_valid_o,
        .mem_req_nline_o,
        .rsp_valid_o     (miss_rsp_valid),
        .rsp_o           (miss_rsp),
        .refill          (refill_if)
    );

    // Miss responses take priority over hits
    assign rsp_in[0] = miss_rsp;
    assign rsp_in[1] = lookup_rsp;

    hpdcache_fxarb #(
        .N          (hpdcache_pkg::RSP_SOURCES),
        .payload_t  (hpdcache_pkg::hpdcache_rsp_t)
    ) rsp_arbiter_i (
        .clk_i,
        .rst_n_i,
        .req_valid_i ({lookup_rsp_valid, miss_rsp_valid}),
        .payload_i   (rsp_in),
        .ready_i     (rsp_ready),
        .req_ready_o (rsp_in_ready),
        .valid_o     (rsp_valid),
        .payload_o   (rsp),
        .gnt_o       ()
    );

    always_comb begin
        for (int i = 0; i < hpdcache_pkg::NREQUESTERS; i++) begin
            core_rsp_valid_o[i] = rsp_valid && (int'(rsp.sid) == i);
        end
    end

    assign rsp_ready       = core_rsp_ready_i[rsp.sid];
    assign core_rsp_data_o = rsp.data;
    assign core_rsp_tid_o  = rsp.tid;

endmodule

// File: verification/hpdcache_tb.sv
// Testbench for the read-only data cache with memory model and response checker
`timescale 1ns/10ps
module hpdcache_tb;

    localparam int TIMEOUT = 2000;

    logic                                                           clk_i = 1'b0;
    logic                                                           rst_n_i;
    logic [hpdcache_pkg::NREQUESTERS-1:0]                           core_req_valid_i;
    logic [hpdcache_pkg::NREQUESTERS-1:0]                           core_req_ready_o;
    logic [hpdcache_pkg::NREQUESTERS-1:0][hpdcache_pkg::ADDR_WIDTH-1:0] core_req_addr_i;
    logic [hpdcache_pkg::NREQUESTERS-1:0][hpdcache_pkg::TID_WIDTH-1:0]  core_req_tid_i;
    logic [hpdcache_pkg::NREQUESTERS-1:0]                           core_rsp_valid_o;
    logic [hpdcache_pkg::NREQUESTERS-1:0]                           core_rsp_ready_i = '1;
    logic [31:0]                                                    core_rsp_data_o;
    logic [3:0]                                                     core_rsp_tid_o;
    logic                                                           mem_req_ready_i = 1'b0;
    logic                                                           mem_req_valid_o;
    logic [11:0]                                                    mem_req_nline_o;
    logic                                                           mem_rsp_valid_i = 1'b0;
    logic [127:0]                                                   mem_rsp_data_i = '0;
    logic                                                           cfg_enable_i;
    logic                                                           evt_read_req_o;
    logic                                                           evt_read_miss_o;

    logic [31:0] lcg_state = 32'd55;
    logic        random_bp = 1'b0;
    string       test_name = "reset";
    int          cycle = 0;
    int          accepted = 0;
    int          outstanding = 0;
    int          mem_reqs = 0;
    int          evt_req_cnt = 0;
    int          evt_miss_cnt = 0;
    logic [11:0] last_nline = '0;
    logic        pending [2][16];
    logic [15:0] pend_addr [2][16];
    logic [3:0]  next_tid [2];
    int          accept_cycle [2];
    logic        mem_busy = 1'b0;
    logic [11:0] mem_nline = '0;
    int          mem_delay = 0;

    hpdcache hpdcache_inst (.*);

    always #50 clk_i = ~clk_i;

    function automatic int next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'(lcg_state[30:16]);
    endfunction

    // Word w of line n holds n * 16 + w
    function automatic logic [31:0] expected_word(input logic [15:0] addr);
        return 32'(addr[15:4]) * 32'd16 + 32'(addr[3:2]);
    endfunction

    function automatic logic [127:0] line_data(input logic [11:0] nline);
        logic [127:0] line;
        for (int w = 0; w < 4; w++) begin
            line[w*32 +: 32] = 32'(nline) * 32'd16 + 32'(w);
        end
        return line;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("FAILED %s: expected %0h, actual %0h", name, expected, actual));
        end
    endtask

    task automatic issue(input int r, input logic [15:0] addr);
        int         waited;
        logic [3:0] tid;
        tid = next_tid[r];
        next_tid[r] = next_tid[r] + 4'd1;
        waited = 0;
        @(negedge clk_i);
        while (pending[r][tid]) begin
            waited++;
            if (waited > TIMEOUT) begin
                fail_run($sformatf("Requester %0d never got tid %0d back", r, tid));
            end
            @(negedge clk_i);
        end
        core_req_valid_i[r] = 1'b1;
        core_req_addr_i[r] = addr;
        core_req_tid_i[r] = tid;
        waited = 0;
        #10;
        while (!core_req_ready_o[r]) begin
            waited++;
            if (waited > TIMEOUT) begin
                fail_run($sformatf("Requester %0d request was never accepted", r));
            end
            @(negedge clk_i);
            #10;
        end
        accept_cycle[r] = cycle;
        @(negedge clk_i);
        core_req_valid_i[r] = 1'b0;
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        @(negedge clk_i);
        while (outstanding != 0) begin
            waited++;
            if (waited > TIMEOUT) begin
                fail_run("Responses still missing after the timeout");
            end
            @(negedge clk_i);
        end
        repeat (2) @(negedge clk_i);
    endtask

    task automatic read(input int r, input logic [15:0] addr);
        issue(r, addr);
        wait_idle();
    endtask

    task automatic random_traffic(input int r, input int count);
        for (int i = 0; i < count; i++) begin
            repeat (next_rand() % 3) @(negedge clk_i);
            issue(r, 16'(next_rand()) & 16'h03fc);
        end
    endtask

    // Memory answers one line fetch at a time after a delay
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            mem_rsp_valid_i = 1'b0;
            if (mem_busy) begin
                if (mem_delay == 0) begin
                    mem_rsp_valid_i = 1'b1;
                    mem_rsp_data_i = line_data(mem_nline);
                    mem_busy = 1'b0;
                end else begin
                    mem_delay--;
                end
            end
            mem_req_ready_i = random_bp ? ((next_rand() % 4) != 0) : 1'b1;
            #10;
            if (mem_req_valid_o && mem_req_ready_i) begin
                mem_busy = 1'b1;
                mem_nline = mem_req_nline_o;
                mem_delay = random_bp ? next_rand() % 6 : 2;
            end
        end
    end

    always @(negedge clk_i) begin
        if (random_bp) begin
            core_rsp_ready_i = {(next_rand() % 3) != 0, (next_rand() % 3) != 0};
        end else begin
            core_rsp_ready_i = '1;
        end
    end

    // Checker samples every handshake in the middle of the low phase
    always @(negedge clk_i) begin
        cycle++;
        #10;
        if (rst_n_i) begin
            check_value("response routing", 32'd1, 32'($onehot0(core_rsp_valid_o)));
            for (int r = 0; r < 2; r++) begin
                if (core_req_valid_i[r] && core_req_ready_o[r]) begin
                    pending[r][core_req_tid_i[r]] = 1'b1;
                    pend_addr[r][core_req_tid_i[r]] = core_req_addr_i[r];
                    accepted++;
                    outstanding++;
                end
                if (core_rsp_valid_o[r] && core_rsp_ready_i[r]) begin
                    if (!pending[r][core_rsp_tid_o]) begin
                        fail_run($sformatf("Requester %0d got tid %0d that it never issued",
                                           r, core_rsp_tid_o));
                    end
                    check_value($sformatf("%s requester %0d tid %0d", test_name, r,
                                          core_rsp_tid_o),
                                expected_word(pend_addr[r][core_rsp_tid_o]), core_rsp_data_o);
                    pending[r][core_rsp_tid_o] = 1'b0;
                    outstanding--;
                end
            end
            if (mem_req_valid_o && mem_req_ready_i) begin
                mem_reqs++;
                last_nline = mem_req_nline_o;
            end
            if (evt_read_req_o) begin
                evt_req_cnt++;
            end
            if (evt_read_miss_o) begin
                evt_miss_cnt++;
            end
        end
    end

    initial begin
        int m0;
        rst_n_i = 1'b0;
        cfg_enable_i = 1'b1;
        core_req_valid_i = '0;
        core_req_addr_i = '0;
        core_req_tid_i = '0;
        for (int r = 0; r < 2; r++) begin
            next_tid[r] = 4'(r * 8);
            accept_cycle[r] = 0;
            for (int t = 0; t < 16; t++) begin
                pending[r][t] = 1'b0;
                pend_addr[r][t] = '0;
            end
        end
        repeat (8) @(negedge clk_i);
        rst_n_i = 1'b1;
        repeat (2) @(negedge clk_i);

        test_name = "first read";
        m0 = mem_reqs;
        read(0, 16'h0124);
        check_value("first read mem requests", 32'(m0 + 1), 32'(mem_reqs));
        check_value("first read line", 32'h012, 32'(last_nline));
        test_name = "same line";
        read(0, 16'h0128);
        check_value("same line mem requests", 32'(m0 + 1), 32'(mem_reqs));

        // Both lines map to set 4
        test_name = "set conflict";
        for (int i = 0; i < 3; i++) begin
            m0 = mem_reqs;
            read(1, 16'h0340);
            read(1, 16'h1344);
            check_value("set conflict mem requests", 32'(m0 + 2), 32'(mem_reqs));
        end

        test_name = "caching off";
        @(negedge clk_i);
        cfg_enable_i = 1'b0;
        for (int i = 0; i < 3; i++) begin
            m0 = mem_reqs;
            read(0, 16'h0124);
            check_value("caching off mem requests", 32'(m0 + 1), 32'(mem_reqs));
        end
        @(negedge clk_i);
        cfg_enable_i = 1'b1;

        test_name = "priority";
        fork
            issue(0, 16'h0500);
            issue(1, 16'h0604);
        join
        wait_idle();
        check_value("priority grant order", 32'd1,
                    32'(accept_cycle[0] < accept_cycle[1]));

        test_name = "random traffic";
        random_bp = 1'b1;
        fork
            random_traffic(0, 40);
            random_traffic(1, 40);
        join
        wait_idle();
        random_bp = 1'b0;
        repeat (2) @(negedge clk_i);

        check_value("read request events", 32'(accepted), 32'(evt_req_cnt));
        check_value("read miss events", 32'(mem_reqs), 32'(evt_miss_cnt));
        $display("Test passed");
        $finish;
    end

endmodule

// File: compile.f
common/hpdcache_pkg.sv
common/hpdcache_refill_if.sv
design/hpdcache_fxarb.sv
lookup/hpdcache_lookup.sv
miss_handler/hpdcache_miss_handler.sv
design/hpdcache.sv
verification/hpdcache_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module hpdcache_tb -o hpdcache_sim

# A fatal stop exits non-zero, so the log decides the result
./obj_dir/hpdcache_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
if ! grep -q "Test passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
